/* Makefile */
# Verilator build and run for the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -qx "SIMULATION PASSED" $(LOG); then \
		echo "check: pass"; \
	else \
		echo "check: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
logic/rv32i_pkg.sv
logic/issue_if.sv
logic/writeback_if.sv
logic/instr_decode.sv
logic/execute_unit.sv
logic/result_stage.sv
logic/rv32i_core.sv
verification/core_checker.sv
verification/tb_core.sv

/* logic/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    issue_if.exe     iss,
    writeback_if.exe wb
);

    ctrl_word_t cw;
    logic       ack_q;
    logic       fire;
    rv32i_word  op_a;
    rv32i_word  op_b;
    rv32i_word  alu_out;
    rv32i_word  jalr_sum;
    rv32i_word  next_pc;
    rv32i_word  result;
    logic       taken;

    // capture on the first cycle of a new request
    always_ff @(posedge clk) begin
        if (iss.req && !ack_q)
            cw <= iss.ctrl;
    end

    // ack follows req by one cycle and fire marks the rising ack
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            fire  <= 1'b0;
        end else begin
            ack_q <= iss.req;
            fire  <= iss.req && !ack_q;
        end
    end

    assign wb.rs1_addr = cw.rs1;
    assign wb.rs2_addr = cw.rs2;

    assign op_a = wb.rs1_data;
    assign op_b = cw.use_imm ? cw.imm : wb.rs2_data;

    always_comb begin
        case (cw.funct3)
            // sub only exists in the register form
            F3_ADD:  alu_out = (cw.funct7_bit && !cw.use_imm) ? op_a - op_b : op_a + op_b;
            F3_SLL:  alu_out = op_a << op_b[4:0];
            F3_SLT:  alu_out = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            F3_SLTU: alu_out = (op_a < op_b) ? 32'd1 : 32'd0;
            F3_XOR:  alu_out = op_a ^ op_b;
            F3_SR:   alu_out = cw.funct7_bit ? rv32i_word'($signed(op_a) >>> op_b[4:0])
                                             : op_a >> op_b[4:0];
            F3_OR:   alu_out = op_a | op_b;
            F3_AND:  alu_out = op_a & op_b;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (cw.funct3)
            F3_BEQ:  taken = (wb.rs1_data == wb.rs2_data);
            F3_BNE:  taken = (wb.rs1_data != wb.rs2_data);
            F3_BLT:  taken = ($signed(wb.rs1_data) < $signed(wb.rs2_data));
            F3_BGE:  taken = ($signed(wb.rs1_data) >= $signed(wb.rs2_data));
            F3_BLTU: taken = (wb.rs1_data < wb.rs2_data);
            F3_BGEU: taken = (wb.rs1_data >= wb.rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = op_a + cw.imm;

    always_comb begin
        case (cw.uop)
            JALR:    next_pc = {jalr_sum[31:1], 1'b0};
            BRANCH:  next_pc = taken ? cw.pc + cw.imm : cw.link;
            default: next_pc = cw.link;
        endcase
    end

    always_comb begin
        case (cw.uop)
            LUI:     result = cw.imm;
            AUIPC:   result = cw.pc + cw.imm;
            JAL:     result = cw.link;
            JALR:    result = cw.link;
            // a branch retires the pc it resolved to
            BRANCH:  result = next_pc;
            default: result = alu_out;
        endcase
    end

    assign iss.ack            = ack_q;
    assign iss.redirect_valid = fire && ((cw.uop == BRANCH) || (cw.uop == JALR));
    assign iss.redirect_pc    = next_pc;

    assign wb.wb_valid = fire;
    assign wb.wb_rd    = cw.rd;
    assign wb.wb_data  = result;
    assign wb.wb_pc    = cw.pc;

endmodule

/* logic/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output logic      imem_read,
    output rv32i_word imem_addr,
    input  logic      imem_resp,
    input  rv32i_word imem_rdata,
    issue_if.dec      iss
);

    typedef enum logic [2:0] {
        RESET,
        FETCH,
        ISSUE,
        WAIT_ACK_LOW,
        WAIT_REDIRECT
    } state_t;

    state_t state, next_state;

    // fetch pc, and the instruction register with the address it came from
    rv32i_word pc;
    rv32i_word ir;
    rv32i_word ir_pc;
    logic      req_q;

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    reg_idx      rs1;
    reg_idx      rs2;
    reg_idx      rd;
    rv32i_word   i_imm;
    rv32i_word   b_imm;
    rv32i_word   u_imm;
    rv32i_word   j_imm;
    ctrl_word_t  ctrl;
    logic        waits_redirect;

    assign opcode = rv32i_opcode'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign rd     = ir[11:7];

    assign i_imm = {{21{ir[31]}}, ir[30:20]};
    assign b_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign u_imm = {ir[31:12], 12'h000};
    assign j_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    assign imem_read = (state == FETCH);
    assign imem_addr = pc;

    assign iss.req  = req_q;
    assign iss.ctrl = ctrl;

    // branch and jalr targets come back from execute
    assign waits_redirect = (ctrl.uop == BRANCH) || (ctrl.uop == JALR);

    always_comb begin
        ctrl            = '0;
        ctrl.uop        = ALU_OP;
        ctrl.funct3     = funct3;
        ctrl.funct7_bit = ir[30];
        ctrl.rs1        = rs1;
        ctrl.rs2        = rs2;
        ctrl.rd         = rd;
        ctrl.pc         = ir_pc;
        ctrl.link       = ir_pc + 32'd4;

        case (opcode)
            op_lui: begin
                ctrl.uop     = LUI;
                ctrl.rs1     = '0;
                ctrl.rs2     = '0;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = u_imm;
            end
            op_auipc: begin
                ctrl.uop     = AUIPC;
                ctrl.rs1     = '0;
                ctrl.rs2     = '0;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = u_imm;
            end
            op_jal: begin
                ctrl.uop     = JAL;
                ctrl.rs1     = '0;
                ctrl.rs2     = '0;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = j_imm;
            end
            op_jalr: begin
                ctrl.uop     = JALR;
                ctrl.rs2     = '0;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = i_imm;
            end
            op_br: begin
                // rd bits hold part of the offset here
                ctrl.uop = BRANCH;
                ctrl.rd  = '0;
                ctrl.imm = b_imm;
            end
            op_imm: begin
                ctrl.rs2     = '0;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = i_imm;
            end
            op_reg: begin
                ctrl.uop = ALU_OP;
            end
            default: begin
                // unsupported opcodes retire as a nop
                ctrl.rs1 = '0;
                ctrl.rs2 = '0;
                ctrl.rd  = '0;
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: next_state = FETCH;
            FETCH: begin
                if (imem_resp)
                    next_state = ISSUE;
            end
            ISSUE: next_state = waits_redirect ? WAIT_REDIRECT : WAIT_ACK_LOW;
            WAIT_REDIRECT: begin
                if (iss.redirect_valid)
                    next_state = WAIT_ACK_LOW;
            end
            WAIT_ACK_LOW: begin
                // both handshake lines back to low before the next fetch
                if (!req_q && !iss.ack)
                    next_state = FETCH;
            end
            default: next_state = RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RESET;
            pc    <= RESET_PC;
            req_q <= 1'b0;
        end else begin
            state <= next_state;

            if (state == FETCH && imem_resp)
                req_q <= 1'b1;
            else if (iss.ack)
                req_q <= 1'b0;

            if (state == ISSUE && !waits_redirect)
                pc <= (ctrl.uop == JAL) ? ir_pc + j_imm : ctrl.link;
            else if (state == WAIT_REDIRECT && iss.redirect_valid)
                pc <= iss.redirect_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && imem_resp) begin
            ir    <= imem_rdata;
            ir_pc <= pc;
        end
    end

endmodule

/* logic/issue_if.sv */
`timescale 1ns/1ps

interface issue_if
    import rv32i_pkg::*;
();

    // four-phase request from decode
    logic       req;
    ctrl_word_t ctrl;

    // acknowledge from execute
    logic       ack;

    // resolved next pc for branch and jalr pulsed with the rising ack
    logic       redirect_valid;
    rv32i_word  redirect_pc;

    modport dec (
        output req,
        output ctrl,
        input  ack,
        input  redirect_valid,
        input  redirect_pc
    );

    modport exe (
        input  req,
        input  ctrl,
        output ack,
        output redirect_valid,
        output redirect_pc
    );

endinterface

/* logic/result_stage.sv */
`timescale 1ns/1ps

module result_stage
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    writeback_if.res  wb,
    output logic      retire_valid,
    output rv32i_word retire_pc,
    output reg_idx    retire_rd,
    output rv32i_word retire_data
);

    rv32i_word regs [NUM_REGS];

    // x0 is never written, so it keeps its reset value of zero
    assign wb.rs1_data = regs[wb.rs1_addr];
    assign wb.rs2_data = regs[wb.rs2_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb.wb_valid && (wb.wb_rd != '0)) begin
            regs[wb.wb_rd] <= wb.wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            retire_valid <= 1'b0;
        else
            retire_valid <= wb.wb_valid;
    end

    // retire record sampled with the strobe
    always_ff @(posedge clk) begin
        if (wb.wb_valid) begin
            retire_pc   <= wb.wb_pc;
            retire_rd   <= wb.wb_rd;
            retire_data <= wb.wb_data;
        end
    end

endmodule

/* logic/rv32i_core.sv */
`timescale 1ns/1ps

module rv32i_core
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // instruction memory
    output logic      imem_read,
    output rv32i_word imem_addr,
    input  logic      imem_resp,
    input  rv32i_word imem_rdata,

    // retire port
    output logic      retire_valid,
    output rv32i_word retire_pc,
    output reg_idx    retire_rd,
    output rv32i_word retire_data
);

    issue_if     issue_bus ();
    writeback_if wb_bus ();

    instr_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .imem_read  (imem_read),
        .imem_addr  (imem_addr),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .iss        (issue_bus.dec)
    );

    execute_unit u_execute (
        .clk (clk),
        .rst (rst),
        .iss (issue_bus.exe),
        .wb  (wb_bus.exe)
    );

    result_stage u_result (
        .clk          (clk),
        .rst          (rst),
        .wb           (wb_bus.res),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

/* logic/rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  reg_idx;

    localparam rv32i_word RESET_PC = 32'h0000_0000;
    localparam int        NUM_REGS = 32;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // operations carried to execute
    typedef enum logic [2:0] {
        ALU_OP,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BRANCH
    } uop_t;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of the conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        uop_t       uop;
        logic [2:0] funct3;
        logic       funct7_bit;
        reg_idx     rs1;
        reg_idx     rs2;
        reg_idx     rd;
        logic       use_imm;
        rv32i_word  imm;
        rv32i_word  pc;
        rv32i_word  link;
    } ctrl_word_t;

endpackage

/* logic/writeback_if.sv */
`timescale 1ns/1ps

interface writeback_if
    import rv32i_pkg::*;
();

    // register file read ports, combinational data
    reg_idx    rs1_addr;
    reg_idx    rs2_addr;
    rv32i_word rs1_data;
    rv32i_word rs2_data;

    // one-cycle writeback strobe with its retire record
    logic      wb_valid;
    reg_idx    wb_rd;
    rv32i_word wb_data;
    rv32i_word wb_pc;

    modport exe (
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data,
        output wb_valid,
        output wb_rd,
        output wb_data,
        output wb_pc
    );

    modport res (
        input  rs1_addr,
        input  rs2_addr,
        output rs1_data,
        output rs2_data,
        input  wb_valid,
        input  wb_rd,
        input  wb_data,
        input  wb_pc
    );

endinterface

/* verification/core_checker.sv */
`timescale 1ns/1ps

module core_checker
    import rv32i_pkg::*;
#(
    parameter int NUM_ROWS = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         retire_valid,
    input  rv32i_word    retire_pc,
    input  reg_idx       retire_rd,
    input  rv32i_word    retire_data,
    input  logic [127:0] rows [NUM_ROWS],
    output int           retired,
    output int           errors
);

    localparam int ROW_IDX_W = $clog2(NUM_ROWS);

    function automatic logic pc_in_table(rv32i_word pc);
        logic found;
        found = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[ROW_IDX_W'(i)][95:64] == pc)
                found = 1'b1;
        end
        return found;
    endfunction

    function automatic int compare_field(string name, rv32i_word expected, rv32i_word actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // retire records are registered, so the posedge sees the settled values
    always @(posedge clk) begin
        logic [127:0] row;
        int           n;
        if (rst) begin
            retired <= 0;
            errors  <= 0;
        end else if (retire_valid) begin
            n = 0;
            if (retired >= NUM_ROWS) begin
                $display("ERROR at %0t: extra retire at pc %h after the last table entry",
                         $time, retire_pc);
                n = 1;
            end else begin
                row = rows[ROW_IDX_W'(retired)];
                if (retire_pc !== row[95:64] && !pc_in_table(retire_pc)) begin
                    $display("ERROR at %0t: retire at pc %h, an address that is not in the program",
                             $time, retire_pc);
                    n = 1;
                end else if (retire_pc !== row[95:64]) begin
                    // known address but out of order
                    n = compare_field("retire_pc", row[95:64], retire_pc);
                end else begin
                    n = compare_field("retire_rd", row[63:32], rv32i_word'(retire_rd));
                    n += compare_field("retire_data", row[31:0], retire_data);
                end
                retired <= retired + 1;
            end
            errors <= errors + n;
        end
    end

endmodule

/* verification/tb_core.sv */
`timescale 1ns/1ps

module tb_core
    import rv32i_pkg::*;
();

    localparam int        NUM_ROWS       = 33;
    localparam int        ROW_IDX_W      = $clog2(NUM_ROWS);
    localparam int        FETCH_TIMEOUT  = 100;
    localparam int        RETIRE_TIMEOUT = 200;
    localparam rv32i_word NOP            = 32'h0000_0013;

    logic      clk = 1'b0;
    logic      rst;
    logic      imem_read;
    rv32i_word imem_addr;
    logic      imem_resp;
    rv32i_word imem_rdata;
    logic      retire_valid;
    rv32i_word retire_pc;
    reg_idx    retire_rd;
    rv32i_word retire_data;

    int check_errors;
    int retired;
    int fetch_timeouts;
    int retire_timeouts;

    // rows in retire order as {instruction, pc, rd, retire data}
    logic [127:0] prog [NUM_ROWS] = '{
        {32'h123450B7, 32'h0000_0000, 32'd1,  32'h1234_5000},  // lui x1, 0x12345
        {32'h00001117, 32'h0000_0004, 32'd2,  32'h0000_1004},  // auipc x2, 0x1
        {32'h00500193, 32'h0000_0008, 32'd3,  32'h0000_0005},  // addi x3, x0, 5
        {32'hFFD00213, 32'h0000_000C, 32'd4,  32'hFFFF_FFFD},  // addi x4, x0, -3
        {32'h004182B3, 32'h0000_0010, 32'd5,  32'h0000_0002},  // add x5, x3, x4
        {32'h40418333, 32'h0000_0014, 32'd6,  32'h0000_0008},  // sub x6, x3, x4
        {32'h003223B3, 32'h0000_0018, 32'd7,  32'h0000_0001},  // slt x7, x4, x3
        {32'h00323433, 32'h0000_001C, 32'd8,  32'h0000_0000},  // sltu x8, x4, x3
        {32'h00F24493, 32'h0000_0020, 32'd9,  32'hFFFF_FFF2},  // xori x9, x4, 15
        {32'h00419513, 32'h0000_0024, 32'd10, 32'h0000_0050},  // slli x10, x3, 4
        {32'h40125593, 32'h0000_0028, 32'd11, 32'hFFFF_FFFE},  // srai x11, x4, 1
        {32'h01C25613, 32'h0000_002C, 32'd12, 32'h0000_000F},  // srli x12, x4, 28
        {32'h0030E6B3, 32'h0000_0030, 32'd13, 32'h1234_5005},  // or x13, x1, x3
        {32'h00D4F733, 32'h0000_0034, 32'd14, 32'h1234_5000},  // and x14, x9, x13
        {32'h005197B3, 32'h0000_0038, 32'd15, 32'h0000_0014},  // sll x15, x3, x5
        {32'h00718013, 32'h0000_003C, 32'd0,  32'h0000_000C},  // addi x0, x3, 7
        {32'h00300833, 32'h0000_0040, 32'd16, 32'h0000_0005},  // add x16, x0, x3
        {32'h00C008EF, 32'h0000_0044, 32'd17, 32'h0000_0048},  // jal x17, +12
        {32'h01018463, 32'h0000_0050, 32'd0,  32'h0000_0058},  // beq x3, x16 taken
        {32'h01019463, 32'h0000_0058, 32'd0,  32'h0000_005C},  // bne x3, x16 not taken
        {32'h00324463, 32'h0000_005C, 32'd0,  32'h0000_0064},  // blt x4, x3 taken
        {32'h00325463, 32'h0000_0064, 32'd0,  32'h0000_0068},  // bge x4, x3 not taken
        {32'h00326463, 32'h0000_0068, 32'd0,  32'h0000_006C},  // bltu x4, x3 not taken
        {32'h00327463, 32'h0000_006C, 32'd0,  32'h0000_0074},  // bgeu x4, x3 taken
        {32'h00418463, 32'h0000_0074, 32'd0,  32'h0000_0078},  // beq x3, x4 not taken
        {32'h00419463, 32'h0000_0078, 32'd0,  32'h0000_0080},  // bne x3, x4 taken
        {32'h0041C463, 32'h0000_0080, 32'd0,  32'h0000_0084},  // blt x3, x4 not taken
        {32'h0041D463, 32'h0000_0084, 32'd0,  32'h0000_008C},  // bge x3, x4 taken
        {32'h0041E463, 32'h0000_008C, 32'd0,  32'h0000_0094},  // bltu x3, x4 taken
        {32'h0041F463, 32'h0000_0094, 32'd0,  32'h0000_0098},  // bgeu x3, x4 not taken
        {32'h05D50967, 32'h0000_0098, 32'd18, 32'h0000_009C},  // jalr x18, 93(x10) to 0xac
        {32'h00190993, 32'h0000_00AC, 32'd19, 32'h0000_009D},  // addi x19, x18, 1
        {32'h0000006F, 32'h0000_00B0, 32'd0,  32'h0000_00B4}   // jal x0, 0
    };

    rv32i_core dut (
        .clk          (clk),
        .rst          (rst),
        .imem_read    (imem_read),
        .imem_addr    (imem_addr),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    core_checker #(.NUM_ROWS(NUM_ROWS)) chk (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .rows         (prog),
        .retired      (retired),
        .errors       (check_errors)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // memory image comes from the table and skipped addresses read as nop
    function automatic rv32i_word fetch_word(rv32i_word addr);
        rv32i_word word;
        word = NOP;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (prog[ROW_IDX_W'(i)][95:64] == addr)
                word = prog[ROW_IDX_W'(i)][127:96];
        end
        return word;
    endfunction

    task automatic serve_fetches();
        int cycles;
        int delay;
        forever begin
            cycles = 0;
            while (!imem_read && cycles < FETCH_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!imem_read) begin
                $display("ERROR at %0t: no instruction fetch request within %0d cycles",
                         $time, FETCH_TIMEOUT);
                fetch_timeouts++;
            end else begin
                // response latency of 0 to 3 cycles
                delay = $urandom % 4;
                repeat (delay) @(negedge clk);
                imem_rdata = fetch_word(imem_addr);
                imem_resp  = 1'b1;
                @(negedge clk);
                imem_resp  = 1'b0;
            end
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(20));
        rst             = 1'b1;
        imem_resp       = 1'b0;
        imem_rdata      = '0;
        fetch_timeouts  = 0;
        retire_timeouts = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        fork
            serve_fetches();
        join_none
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycles = 0;
            while (retired <= i && cycles < RETIRE_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (retired <= i) begin
                $display("ERROR at %0t: row %0d at pc %h did not retire within %0d cycles",
                         $time, i, prog[ROW_IDX_W'(i)][95:64], RETIRE_TIMEOUT);
                retire_timeouts++;
                break;
            end
        end
        $display("errors: %0d check, %0d fetch timeout, %0d retire timeout; retired %0d of %0d",
                 check_errors, fetch_timeouts, retire_timeouts, retired, NUM_ROWS);
        if (check_errors + fetch_timeouts + retire_timeouts == 0 && retired == NUM_ROWS)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
